// File: rtl/enable_gen_bus_pkg.sv
// Register bus definitions for the enable generator
// Request and response structs of the strobe/ready/read_valid bus
// shared by the decode block and the top level

package enable_gen_bus_pkg;

    // Address and data width of the register bus
    localparam int BUS_WIDTH = 32;

    // Driven by the bus master
    typedef struct packed {
        logic [BUS_WIDTH-1:0] address;
        logic [BUS_WIDTH-1:0] write_data;
        // Accepted only while ready is high
        logic                 write_strobe;
        // Wins over write_strobe when both are set
        logic                 read_strobe;
    } sb_request_t;

    // Returned to the bus master
    typedef struct packed {
        // Low while a write is applied or a read is answered
        logic                 ready;
        // One cycle after an accepted read strobe
        logic                 read_valid;
        // Zero outside read_valid
        logic [BUS_WIDTH-1:0] read_data;
    } sb_response_t;

endpackage

// File: rtl/enable_gen_timing_pkg.sv
// Timer register map for the enable generator
// Register offsets, control bit positions and the struct of applied
// settings that decode hands to the counter, comparator and output stage

package enable_gen_timing_pkg;

    // Width of every timer register
    localparam int SETTING_WIDTH = 32;

    // Offsets from the block base address
    localparam logic [SETTING_WIDTH-1:0] CONTROL_OFFSET   = 32'h00;
    localparam logic [SETTING_WIDTH-1:0] PERIOD_OFFSET    = 32'h04;
    localparam logic [SETTING_WIDTH-1:0] THRESHOLD_OFFSET = 32'h08;

    // Control register bits
    localparam int RUN_BIT        = 0;
    localparam int PULSE_MODE_BIT = 1;

    // Settings as applied after a bus write
    typedef struct packed {
        logic                     run;
        logic                     pulse_mode;
        logic [SETTING_WIDTH-1:0] period;
        logic [SETTING_WIDTH-1:0] threshold;
    } timer_settings_t;

endpackage

// File: rtl/enable_gen_reg_decode.sv
// Register decode for the enable generator
// Latches bus writes, applies them to the timer settings over two
// cycles with ready low, and answers reads with one read_valid cycle

`timescale 1ns/1ps

module enable_gen_reg_decode
    import enable_gen_bus_pkg::*;
    import enable_gen_timing_pkg::*;
#(
    parameter logic [BUS_WIDTH-1:0] BASE_ADDRESS = '0
) (
    input  logic            clock,
    input  logic            reset,
    input  sb_request_t     bus_request,
    output sb_response_t    bus_response,
    output timer_settings_t settings
);

    typedef enum logic {
        idle_state,
        apply_state
    } state_t;

    state_t               state;
    logic                 apply_done;
    logic                 ready;
    logic                 read_valid;
    logic                 idle_ready;
    logic                 read_accept;
    logic                 write_accept;
    logic [BUS_WIDTH-1:0] request_offset;
    logic [BUS_WIDTH-1:0] latched_offset;
    logic [BUS_WIDTH-1:0] latched_data;
    logic [BUS_WIDTH-1:0] control_word;
    logic [BUS_WIDTH-1:0] readback_data;

    assign request_offset = bus_request.address - BASE_ADDRESS;
    assign idle_ready     = (state == idle_state) && ready;
    assign read_accept    = idle_ready && bus_request.read_strobe;
    // Read wins if the master raises both strobes
    assign write_accept   = idle_ready && bus_request.write_strobe
                            && !bus_request.read_strobe;

    // Offset serves both the pending write and the read answer
    always_ff @(posedge clock) begin
        if (read_accept || write_accept) begin
            latched_offset <= request_offset;
            latched_data   <= bus_request.write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state      <= idle_state;
            apply_done <= 1'b0;
            ready      <= 1'b1;
            read_valid <= 1'b0;
            settings   <= '0;
        end else begin
            read_valid <= read_accept;
            case (state)
                idle_state: begin
                    if (read_accept) begin
                        // Hold off new requests during the read_valid cycle
                        ready <= 1'b0;
                    end else if (write_accept) begin
                        ready <= 1'b0;
                        state <= apply_state;
                    end else begin
                        ready <= 1'b1;
                    end
                end
                apply_state: begin
                    if (apply_done) begin
                        apply_done <= 1'b0;
                        ready      <= 1'b1;
                        state      <= idle_state;
                    end else begin
                        // New setting visible from the next cycle
                        apply_done <= 1'b1;
                        case (latched_offset)
                            CONTROL_OFFSET: begin
                                settings.run        <= latched_data[RUN_BIT];
                                settings.pulse_mode <= latched_data[PULSE_MODE_BIT];
                            end
                            PERIOD_OFFSET: begin
                                settings.period <= latched_data;
                            end
                            THRESHOLD_OFFSET: begin
                                settings.threshold <= latched_data;
                            end
                            default: begin
                                // Unmapped writes are dropped
                            end
                        endcase
                    end
                end
                default: begin
                    state <= idle_state;
                end
            endcase
        end
    end

    // Readback straight from the applied settings
    always_comb begin
        control_word                 = '0;
        control_word[RUN_BIT]        = settings.run;
        control_word[PULSE_MODE_BIT] = settings.pulse_mode;
        case (latched_offset)
            CONTROL_OFFSET:   readback_data = control_word;
            PERIOD_OFFSET:    readback_data = settings.period;
            THRESHOLD_OFFSET: readback_data = settings.threshold;
            default:          readback_data = '0;
        endcase
    end

    always_comb begin
        bus_response.ready      = ready;
        bus_response.read_valid = read_valid;
        bus_response.read_data  = read_valid ? readback_data : '0;
    end

    // Ready back high after at most two low cycles
    assert property (@(posedge clock) disable iff (!reset)
        !ready ##1 !ready |=> ready);

    // Single read_valid cycle per accepted read
    assert property (@(posedge clock) disable iff (!reset)
        read_valid |=> !read_valid);

endmodule

// File: rtl/enable_gen_counter.sv
// Period counter for the enable generator
// Counts while the run bit or gen_enable_in is high and wraps to zero
// after period minus one

`timescale 1ns/1ps

module enable_gen_counter
    import enable_gen_timing_pkg::*;
#(
    parameter int COUNTER_WIDTH = 32
) (
    input  logic                     clock,
    input  logic                     reset,
    input  timer_settings_t          settings,
    input  logic                     gen_enable_in,
    output logic [COUNTER_WIDTH-1:0] count
);

    logic                     enabled;
    logic                     at_wrap;
    logic [COUNTER_WIDTH-1:0] period;

    // Either source keeps the counter running
    assign enabled = settings.run || gen_enable_in;

    // Only the low bits of the programmed period take part
    assign period = settings.period[COUNTER_WIDTH-1:0];

    // Period 0 or 1 pins the count at zero.
    // A count past a freshly shortened period also wraps here
    assign at_wrap = (period <= 1) || (count >= period - 1'b1);

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
        end else if (enabled) begin
            if (at_wrap) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // A step never leaves the count at or beyond the period
    assert property (@(posedge clock) disable iff (!reset)
        enabled && (period > 1) |=> count < $past(period));

endmodule

// File: rtl/enable_gen_comparator.sv
// Threshold comparator for the enable generator
// Registers whether the count has reached the threshold; every enable
// is derived from this level

`timescale 1ns/1ps

module enable_gen_comparator
    import enable_gen_timing_pkg::*;
#(
    parameter int COUNTER_WIDTH = 32
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [COUNTER_WIDTH-1:0] count,
    input  timer_settings_t          settings,
    output logic                     compare_level
);

    logic [COUNTER_WIDTH-1:0] threshold;

    assign threshold = settings.threshold[COUNTER_WIDTH-1:0];

    // High from threshold up to the wrap, so period minus threshold cycles
    always_ff @(posedge clock) begin
        if (!reset) begin
            compare_level <= 1'b0;
        end else begin
            compare_level <= (count >= threshold);
        end
    end

endmodule

// File: rtl/enable_gen_output_stage.sv
// Output stage for the enable generator
// Level mode registers the compare level, pulse mode gives one
// cycle of enable per rising edge of the compare level

`timescale 1ns/1ps

module enable_gen_output_stage
    import enable_gen_timing_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            compare_level,
    input  timer_settings_t settings,
    output logic            enable_out
);

    logic previous_level;
    logic rising_edge;

    assign rising_edge = compare_level && !previous_level;

    always_ff @(posedge clock) begin
        if (!reset) begin
            previous_level <= 1'b0;
            enable_out     <= 1'b0;
        end else begin
            previous_level <= compare_level;
            if (settings.pulse_mode) begin
                enable_out <= rising_edge;
            end else begin
                enable_out <= compare_level;
            end
        end
    end

    // Pulses stay single cycle once pulse mode is in place
    assert property (@(posedge clock) disable iff (!reset)
        (settings.pulse_mode && enable_out) ##1 settings.pulse_mode |-> !enable_out);

endmodule

// File: rtl/enable_generator.sv
// Bus-programmable enable generator
// Register decode feeds a period counter and threshold comparator,
// whose level the output stage passes on or turns into pulses

`timescale 1ns/1ps

module enable_generator
    import enable_gen_bus_pkg::*;
    import enable_gen_timing_pkg::*;
#(
    parameter logic [BUS_WIDTH-1:0] BASE_ADDRESS  = '0,
    parameter int                   COUNTER_WIDTH = 32
) (
    input  logic         clock,
    input  logic         reset,
    input  sb_request_t  bus_request,
    output sb_response_t bus_response,
    input  logic         gen_enable_in,
    output logic         enable_out
);

    timer_settings_t          settings;
    logic [COUNTER_WIDTH-1:0] count;
    logic                     compare_level;

    enable_gen_reg_decode #(
        .BASE_ADDRESS(BASE_ADDRESS)
    ) decode (
        .clock       (clock),
        .reset       (reset),
        .bus_request (bus_request),
        .bus_response(bus_response),
        .settings    (settings)
    );

    enable_gen_counter #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) counter (
        .clock        (clock),
        .reset        (reset),
        .settings     (settings),
        .gen_enable_in(gen_enable_in),
        .count        (count)
    );

    enable_gen_comparator #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) comparator (
        .clock        (clock),
        .reset        (reset),
        .count        (count),
        .settings     (settings),
        .compare_level(compare_level)
    );

    // Count to enable_out is two registered stages
    enable_gen_output_stage output_stage (
        .clock        (clock),
        .reset        (reset),
        .compare_level(compare_level),
        .settings     (settings),
        .enable_out   (enable_out)
    );

endmodule

// File: verification/enable_generator_tb_tasks.svh
// Testbench helpers for the enable generator
// Compare tasks, LFSR, bus write and read tasks with timeouts,
// and enable_out measurement over a window of cycles

`ifndef ENABLE_GENERATOR_TB_TASKS_SVH
`define ENABLE_GENERATOR_TB_TASKS_SVH

task automatic check_level(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
        error_count++;
    end
endtask

task automatic check_count(input string name, input int unsigned expected,
                           input int unsigned actual);
    if (actual !== expected) begin
        $display("error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
        error_count++;
    end
endtask

// Ready is not part of the read answer, only valid and data
task automatic check_response(input string name, input sb_response_t expected,
                              input sb_response_t actual);
    if (actual.read_valid !== expected.read_valid) begin
        $display("error: bus_response.read_valid expected 0x%0h actual 0x%0h (%s)",
                 expected.read_valid, actual.read_valid, name);
        error_count++;
    end
    if (actual.read_data !== expected.read_data) begin
        $display("error: bus_response.read_data expected 0x%0h actual 0x%0h (%s)",
                 expected.read_data, actual.read_data, name);
        error_count++;
    end
endtask

// Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] take_random_bits(input int bit_count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < bit_count; i++) begin
        bits = {bits[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return bits;
endfunction

task automatic wait_for_ready();
    int unsigned cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
        @(negedge clock);
        if (bus_response.ready) begin
            return;
        end
        cycles++;
    end
    $display("timeout: ready stayed low for %0d cycles", TIMEOUT_CYCLES);
    error_count++;
endtask

task automatic bus_write(input logic [BUS_WIDTH-1:0] offset,
                         input logic [BUS_WIDTH-1:0] data);
    int unsigned low_cycles;
    wait_for_ready();
    @(posedge clock);
    bus_request.address      <= BASE_ADDRESS + offset;
    bus_request.write_data   <= data;
    bus_request.write_strobe <= 1'b1;
    @(posedge clock);
    bus_request.write_strobe <= 1'b0;
    // Ready should stay low for exactly two cycles
    low_cycles = 0;
    while (low_cycles <= TIMEOUT_CYCLES) begin
        @(negedge clock);
        if (bus_response.ready) begin
            break;
        end
        low_cycles++;
    end
    if (!bus_response.ready) begin
        $display("timeout: ready did not return after a write to offset 0x%0h", offset);
        error_count++;
    end else begin
        check_count("bus_response.ready low cycles", 2, low_cycles);
    end
endtask

task automatic bus_read_check(input logic [BUS_WIDTH-1:0] offset,
                              input logic [BUS_WIDTH-1:0] expected_data,
                              input string name);
    sb_response_t expected;
    int unsigned  cycles;
    wait_for_ready();
    @(posedge clock);
    bus_request.address     <= BASE_ADDRESS + offset;
    bus_request.read_strobe <= 1'b1;
    @(posedge clock);
    bus_request.read_strobe <= 1'b0;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
        @(negedge clock);
        cycles++;
        if (bus_response.read_valid) begin
            break;
        end
    end
    if (!bus_response.read_valid) begin
        $display("timeout: no read_valid for the %s read", name);
        error_count++;
        return;
    end
    check_count("bus_response.read_valid delay", 1, cycles);
    expected            = '0;
    expected.read_valid = 1'b1;
    expected.read_data  = expected_data;
    check_response(name, expected, bus_response);
    // Data must drop back to zero with read_valid
    @(negedge clock);
    expected = '0;
    check_response({name, " after read_valid"}, expected, bus_response);
endtask

task automatic measure_enable(input int unsigned cycles, output int unsigned high_cycles,
                              output int unsigned longest_run);
    int unsigned run;
    high_cycles = 0;
    longest_run = 0;
    run         = 0;
    repeat (cycles) begin
        @(negedge clock);
        if (enable_out) begin
            high_cycles++;
            run++;
            if (run > longest_run) begin
                longest_run = run;
            end
        end else begin
            run = 0;
        end
    end
endtask

task automatic count_enable_changes(input int unsigned cycles, output int unsigned changes);
    logic previous;
    changes  = 0;
    previous = enable_out;
    repeat (cycles) begin
        @(negedge clock);
        if (enable_out !== previous) begin
            changes++;
        end
        previous = enable_out;
    end
endtask

`endif

// File: verification/enable_generator_tb.sv
// Testbench for the enable generator
// Checks reset state and register readback over the bus, then runs a
// table of period and threshold settings and counts enable_out cycles

`timescale 1ns/1ps

module enable_generator_tb
    import enable_gen_bus_pkg::*;
    import enable_gen_timing_pkg::*;
();

    localparam logic [BUS_WIDTH-1:0] BASE_ADDRESS   = 32'h100;
    localparam int unsigned          TIMEOUT_CYCLES = 50;
    localparam int                   ROW_COUNT      = 11;

    typedef struct packed {
        logic [31:0] period;
        logic [31:0] threshold;
        logic        pulse_mode;
        logic        use_gen_enable;
        logic [31:0] periods;
        logic        random_values;
    } stimulus_row_t;

    logic          clock = 1'b0;
    logic          reset;
    sb_request_t   bus_request;
    sb_response_t  bus_response;
    logic          gen_enable_in;
    logic          enable_out;
    int unsigned   error_count;
    int unsigned   pass_count;
    int unsigned   fail_count;
    logic [31:0]   lfsr_state;
    stimulus_row_t stimulus_table [ROW_COUNT];

    `include "enable_generator_tb_tasks.svh"

    always #4 clock = ~clock;

    enable_generator #(
        .BASE_ADDRESS (BASE_ADDRESS),
        .COUNTER_WIDTH(32)
    ) dut0 (
        .clock        (clock),
        .reset        (reset),
        .bus_request  (bus_request),
        .bus_response (bus_response),
        .gen_enable_in(gen_enable_in),
        .enable_out   (enable_out)
    );

    function automatic stimulus_row_t make_row(input int unsigned period,
            input int unsigned threshold, input logic pulse_mode,
            input logic use_gen_enable, input int unsigned periods, input logic random_values);
        stimulus_row_t row;
        row.period         = period;
        row.threshold      = threshold;
        row.pulse_mode     = pulse_mode;
        row.use_gen_enable = use_gen_enable;
        row.periods        = periods;
        row.random_values  = random_values;
        return row;
    endfunction

    task automatic load_stimulus_table();
        stimulus_table[0]  = make_row(10, 4, 1'b0, 1'b0, 3, 1'b0);
        stimulus_table[1]  = make_row(7, 0, 1'b0, 1'b0, 2, 1'b0);
        // Threshold at the period never fires
        stimulus_table[2]  = make_row(6, 6, 1'b0, 1'b0, 2, 1'b0);
        stimulus_table[3]  = make_row(12, 5, 1'b1, 1'b0, 3, 1'b0);
        stimulus_table[4]  = make_row(5, 1, 1'b1, 1'b0, 4, 1'b0);
        stimulus_table[5]  = make_row(9, 3, 1'b0, 1'b1, 3, 1'b0);
        stimulus_table[6]  = make_row(8, 2, 1'b1, 1'b1, 2, 1'b0);
        stimulus_table[7]  = make_row(16, 15, 1'b0, 1'b0, 2, 1'b0);
        // Period and threshold filled from the LFSR
        stimulus_table[8]  = make_row(0, 0, 1'b0, 1'b0, 3, 1'b1);
        stimulus_table[9]  = make_row(0, 0, 1'b0, 1'b0, 3, 1'b1);
        stimulus_table[10] = make_row(0, 0, 1'b0, 1'b1, 2, 1'b1);
    endtask

    task automatic finish_test(input string name, input int unsigned errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic run_row(input int index);
        stimulus_row_t row;
        logic [31:0]   period;
        logic [31:0]   threshold;
        logic [31:0]   control;
        int unsigned   expected_high;
        int unsigned   high_cycles;
        int unsigned   longest_run;
        int unsigned   changes;
        int unsigned   errors_before;
        string         name;
        row           = stimulus_table[index];
        errors_before = error_count;
        period        = row.period;
        threshold     = row.threshold;
        if (row.random_values) begin
            period    = 2 + (take_random_bits(6) % 39);
            threshold = take_random_bits(6) % period;
        end
        name = $sformatf("row %0d period %0d threshold %0d %s by %s", index, period,
                         threshold, row.pulse_mode ? "pulse" : "level",
                         row.use_gen_enable ? "gen_enable_in" : "run bit");
        control                 = '0;
        control[PULSE_MODE_BIT] = row.pulse_mode;
        control[RUN_BIT]        = !row.use_gen_enable;

        bus_write(CONTROL_OFFSET, '0);
        bus_write(PERIOD_OFFSET, period);
        bus_read_check(PERIOD_OFFSET, period, "period readback");
        bus_write(THRESHOLD_OFFSET, threshold);
        bus_read_check(THRESHOLD_OFFSET, threshold, "threshold readback");
        bus_write(CONTROL_OFFSET, control);
        bus_read_check(CONTROL_OFFSET, control, "control readback");
        if (row.use_gen_enable) begin
            @(posedge clock);
            gen_enable_in <= 1'b1;
        end

        // One period to leave any stale count, then the two stage pipeline
        repeat (period + 4) @(negedge clock);
        measure_enable(row.periods * period, high_cycles, longest_run);
        if (row.pulse_mode) begin
            expected_high = row.periods;
            check_count("enable_out run length", 1, longest_run);
        end else if (threshold < period) begin
            expected_high = row.periods * (period - threshold);
        end else begin
            expected_high = 0;
        end
        check_count("enable_out high cycles", expected_high, high_cycles);

        // Output must hold with both sources off
        @(posedge clock);
        gen_enable_in <= 1'b0;
        control[RUN_BIT] = 1'b0;
        bus_write(CONTROL_OFFSET, control);
        repeat (4) @(negedge clock);
        count_enable_changes(2 * period, changes);
        check_count("enable_out changes while stopped", 0, changes);
        finish_test(name, errors_before);
    endtask

    initial begin
        sb_response_t expected_response;
        int unsigned  errors_before;
        reset         = 1'b0;
        gen_enable_in = 1'b0;
        bus_request   = '0;
        error_count   = 0;
        pass_count    = 0;
        fail_count    = 0;
        lfsr_state    = 32'd70271;
        load_stimulus_table();
        repeat (4) @(posedge clock);
        reset <= 1'b1;

        errors_before = error_count;
        @(negedge clock);
        expected_response = '0;
        check_level("bus_response.ready", 1'b1, bus_response.ready);
        check_response("reset state", expected_response, bus_response);
        check_level("enable_out", 1'b0, enable_out);
        bus_read_check(CONTROL_OFFSET, '0, "control after reset");
        bus_read_check(PERIOD_OFFSET, '0, "period after reset");
        bus_read_check(THRESHOLD_OFFSET, '0, "threshold after reset");
        finish_test("reset state", errors_before);

        errors_before = error_count;
        bus_write(PERIOD_OFFSET, 32'h0000_002a);
        bus_read_check(PERIOD_OFFSET, 32'h0000_002a, "period readback");
        bus_write(THRESHOLD_OFFSET, 32'h0000_0015);
        bus_read_check(THRESHOLD_OFFSET, 32'h0000_0015, "threshold readback");
        bus_read_check(32'h0c, '0, "unmapped offset");
        finish_test("write and readback", errors_before);

        for (int i = 0; i < ROW_COUNT; i++) begin
            run_row(i);
        end

        $display("pass count %0d, fail count %0d", pass_count, fail_count);
        if (error_count == 0 && fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verification
rtl/enable_gen_bus_pkg.sv
rtl/enable_gen_timing_pkg.sv
rtl/enable_gen_reg_decode.sv
rtl/enable_gen_counter.sv
rtl/enable_gen_comparator.sv
rtl/enable_gen_output_stage.sv
rtl/enable_generator.sv
verification/enable_generator_tb.sv
